// ==== logic/mspi_apb_regs.sv ====
// APB register front end of the SPI master
// Command and status registers, buffer windows and the pclk half of the
// start handshake into the sclk domain

`timescale 1ns/1ps
`include "mspi_params.svh"

module mspi_apb_regs (
    input  logic                pclk,
    input  logic                rst_n_pclk,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [11:0]         paddr,
    input  mspi_pkg::word_t     pwdata,
    output mspi_pkg::word_t     prdata,
    output logic                pslverr,
    output logic                tx_wr_en,
    output mspi_pkg::buf_addr_t tx_wr_addr,
    output mspi_pkg::word_t     tx_wr_data,
    output mspi_pkg::buf_addr_t rx_rd_addr,
    input  mspi_pkg::word_t     rx_rd_data,
    output mspi_pkg::word_t     cmd_word,
    output logic                cdc_req,
    output logic                start_level,
    input  logic                ack_sclk,
    input  logic                active_sclk
);
    import mspi_pkg::*;

    reg_region_e region;
    cdc_state_e  cdc_state;
    logic        apb_access;
    logic        apb_wr;
    logic        apb_rd;
    logic        cmd_wr;
    logic        cmd_lock;
    logic        ack_pclk;
    logic        active_pclk;
    logic        active_pclk_d;
    logic        done_set;
    logic        done;
    logic        hs_busy;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    // Bits 11:10 pick the window, low bits the register
    always_comb begin
        case (paddr[11:10])
            2'b00: begin
                if (paddr[9:0] == 10'h000) begin
                    region = REGION_CMD;
                end else if (paddr[9:0] == 10'h004) begin
                    region = REGION_STATUS;
                end else begin
                    region = REGION_NONE;
                end
            end
            2'b01:   region = REGION_TXBUF;
            2'b10:   region = REGION_RXBUF;
            default: region = REGION_NONE;
        endcase
    end

    // Zero wait states, so the access phase is the whole transfer
    assign apb_access = psel & penable;
    assign apb_wr     = apb_access & pwrite;
    assign apb_rd     = apb_access & ~pwrite;
    assign cmd_wr     = apb_wr & (region == REGION_CMD);

    // Buffer windows share the word offset
    assign tx_wr_en   = apb_wr & (region == REGION_TXBUF);
    assign tx_wr_addr = paddr[`MSPI_BUF_AW+1:2];
    assign tx_wr_data = pwdata;
    assign rx_rd_addr = paddr[`MSPI_BUF_AW+1:2];

    ////////////////////////////////////////
    // Command and status
    ////////////////////////////////////////

    // Lock from start rising until done, engine may latch cmd_word any time in between
    always_ff @(posedge pclk or negedge rst_n_pclk) begin
        if (!rst_n_pclk) begin
            cmd_word <= '0;
            cmd_lock <= 1'b0;
        end else begin
            if (cmd_wr && !cmd_lock) begin
                cmd_word <= pwdata;
            end
            if (cmd_wr && !cmd_lock && pwdata[0] && !cmd_word[0]) begin
                cmd_lock <= 1'b1;
            end else if (done_set) begin
                cmd_lock <= 1'b0;
            end
        end
    end

    // Engine activity seen in pclk, falling edge ends a transfer
    assign done_set = active_pclk_d & ~active_pclk;

    always_ff @(posedge pclk or negedge rst_n_pclk) begin
        if (!rst_n_pclk) begin
            active_pclk_d <= 1'b0;
            done          <= 1'b0;
        end else begin
            active_pclk_d <= active_pclk;
            // Sticky until software touches CMD
            if (done_set) begin
                done <= 1'b1;
            end else if (cmd_wr) begin
                done <= 1'b0;
            end
        end
    end

    assign hs_busy = (cdc_state == CDC_WAIT_ONE) || (cdc_state == CDC_WAIT_ZERO);

    ////////////////////////////////////////
    // Start handshake
    ////////////////////////////////////////

    // Request out, ack is the request back from sclk
    always_ff @(posedge pclk or negedge rst_n_pclk) begin
        if (!rst_n_pclk) begin
            cdc_state   <= CDC_ZERO;
            cdc_req     <= 1'b0;
            start_level <= 1'b0;
        end else begin
            case (cdc_state)
                CDC_ZERO: begin
                    if (cmd_word[0] && !ack_pclk) begin
                        cdc_state <= CDC_WAIT_ONE;
                        cdc_req   <= 1'b1;
                    end
                end
                CDC_WAIT_ONE: begin
                    if (ack_pclk) begin
                        cdc_state   <= CDC_ONE;
                        cdc_req     <= 1'b0;
                        start_level <= 1'b1;
                    end
                end
                CDC_ONE: begin
                    if (!cmd_word[0] && !ack_pclk) begin
                        cdc_state <= CDC_WAIT_ZERO;
                        cdc_req   <= 1'b1;
                    end
                end
                default: begin
                    if (ack_pclk) begin
                        cdc_state   <= CDC_ZERO;
                        cdc_req     <= 1'b0;
                        start_level <= 1'b0;
                    end
                end
            endcase
        end
    end

    spi_bitsync u_sync_ack (
        .clk      (pclk),
        .rst_n    (rst_n_pclk),
        .data_in  (ack_sclk),
        .data_out (ack_pclk)
    );

    spi_bitsync u_sync_active (
        .clk      (pclk),
        .rst_n    (rst_n_pclk),
        .data_in  (active_sclk),
        .data_out (active_pclk)
    );

    ////////////////////////////////////////
    // Read data and errors
    ////////////////////////////////////////

    always_comb begin
        case (region)
            REGION_CMD:    prdata = cmd_word;
            REGION_STATUS: prdata = {30'd0, done, hs_busy};
            REGION_RXBUF:  prdata = rx_rd_data;
            default:       prdata = '0;
        endcase
    end

    // RXBUF is read only, TXBUF write only
    assign pslverr = (apb_wr & (region == REGION_RXBUF))
                   | (apb_rd & (region == REGION_TXBUF))
                   | (apb_access & (region == REGION_NONE));

endmodule

// ==== logic/mspi_buf.sv ====
// Dual-clock word buffer
// Clocked write port, combinational read port from any domain

`timescale 1ns/1ps
`include "mspi_params.svh"

module mspi_buf (
    input  logic                wr_clk,
    input  logic                wr_en,
    input  mspi_pkg::buf_addr_t wr_addr,
    input  mspi_pkg::word_t     wr_data,
    input  mspi_pkg::buf_addr_t rd_addr,
    output mspi_pkg::word_t     rd_data
);
    import mspi_pkg::*;

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    word_t mem [`MSPI_BUF_SIZE];

    // Write side owns the clock
    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    ////////////////////////////////////////
    // Read side
    ////////////////////////////////////////

    // No read clock
    // The reader keeps rd_addr stable while it uses the data
    assign rd_data = mem[rd_addr];

endmodule

// ==== logic/mspi_intf.sv ====
// SPI engine in the sclk domain
// Shifts buffer words out on mosi, collects miso into the receive buffer
// and drives the active-low slave selects

`timescale 1ns/1ps
`include "mspi_params.svh"

module mspi_intf (
    input  logic                     sclk,
    input  logic                     rst_n_sclk,
    input  mspi_pkg::word_t          cmd_word,
    input  logic                     cdc_req,
    input  logic                     start_level,
    output logic                     ack_sclk,
    output mspi_pkg::buf_addr_t      tx_rd_addr,
    input  mspi_pkg::word_t          tx_rd_data,
    output logic                     rx_wr_en,
    output mspi_pkg::buf_addr_t      rx_wr_addr,
    output mspi_pkg::word_t          rx_wr_data,
    output logic                     spi_active,
    output logic [`MSPI_SS_WIDTH-1:0] ss_n,
    output logic                     mosi,
    input  logic [`MSPI_SS_WIDTH-1:0] miso
);
    import mspi_pkg::*;

    logic      start_sync;
    logic      start_d;
    logic      start_pulse;
    word_t     cmd_lat;
    buf_addr_t last_wd;
    logic [1:0] cs_sel;
    logic      trans_enable;
    logic      trans_enable_d;
    logic [4:0] bit_cnt;
    buf_addr_t wd_cnt;
    logic      last_bit;
    word_t     tx_data;
    logic      miso_sel;
    logic      sel_low;
    logic [4:0] rx_bit_cnt;
    buf_addr_t rx_wd_cnt;
    word_t     rx_shift;

    ////////////////////////////////////////
    // Start from pclk
    ////////////////////////////////////////

    // Request loops straight back as the ack
    spi_bitsync u_sync_req (
        .clk      (sclk),
        .rst_n    (rst_n_sclk),
        .data_in  (cdc_req),
        .data_out (ack_sclk)
    );

    spi_bitsync u_sync_start (
        .clk      (sclk),
        .rst_n    (rst_n_sclk),
        .data_in  (start_level),
        .data_out (start_sync)
    );

    assign start_pulse = start_sync & ~start_d;

    // cmd_word has been stable for two syncs by the time the pulse fires
    always_ff @(posedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            start_d <= 1'b0;
            cmd_lat <= '0;
        end else begin
            start_d <= start_sync;
            if (start_pulse) begin
                cmd_lat <= cmd_word;
            end
        end
    end

    assign last_wd = cmd_lat[`MSPI_BUF_AW+1:2];
    assign cs_sel  = cmd_lat[31:30];

    ////////////////////////////////////////
    // Transmit
    ////////////////////////////////////////

    assign last_bit   = &bit_cnt;
    assign spi_active = trans_enable | trans_enable_d;

    // Read address stays one word ahead of the shifter
    always_ff @(posedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            trans_enable   <= 1'b0;
            trans_enable_d <= 1'b0;
            bit_cnt        <= '0;
            wd_cnt         <= '0;
            tx_rd_addr     <= '0;
        end else begin
            if (start_pulse) begin
                trans_enable <= 1'b1;
            end else if (last_bit && (wd_cnt == last_wd)) begin
                trans_enable <= 1'b0;
            end
            trans_enable_d <= trans_enable;
            if (trans_enable) begin
                bit_cnt <= bit_cnt + 5'd1;
                if (last_bit) begin
                    wd_cnt <= wd_cnt + 1'b1;
                end
            end else begin
                bit_cnt <= '0;
                wd_cnt  <= '0;
            end
            if (start_pulse || (trans_enable && last_bit)) begin
                tx_rd_addr <= tx_rd_addr + 1'b1;
            end else if (!spi_active) begin
                tx_rd_addr <= '0;
            end
        end
    end

    // Load at each word boundary, MSB first
    always_ff @(posedge sclk) begin
        if (start_pulse || (trans_enable && last_bit)) begin
            tx_data <= tx_rd_data;
        end else begin
            tx_data <= {tx_data[30:0], 1'b0};
        end
    end

    // Outputs move on the falling edge, half a cycle before the slave samples
    always_ff @(negedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            ss_n <= '1;
            mosi <= 1'b0;
        end else begin
            ss_n         <= '1;
            ss_n[cs_sel] <= ~trans_enable;
            mosi         <= trans_enable & tx_data[31];
        end
    end

    ////////////////////////////////////////
    // Receive
    ////////////////////////////////////////

    // Only the selected slave reaches the shifter
    assign miso_sel = miso[cs_sel];
    assign sel_low  = ~ss_n[cs_sel];

    // Own count of rising-edge samples inside the select window
    always_ff @(posedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            rx_bit_cnt <= '0;
            rx_wd_cnt  <= '0;
            rx_wr_en   <= 1'b0;
            rx_wr_addr <= '0;
        end else begin
            rx_wr_en <= 1'b0;
            if (sel_low) begin
                rx_bit_cnt <= rx_bit_cnt + 5'd1;
                if (&rx_bit_cnt) begin
                    rx_wr_en   <= 1'b1;
                    rx_wr_addr <= rx_wd_cnt;
                    rx_wd_cnt  <= rx_wd_cnt + 1'b1;
                end
            end else begin
                rx_bit_cnt <= '0;
                rx_wd_cnt  <= '0;
            end
        end
    end

    always_ff @(posedge sclk) begin
        if (sel_low) begin
            rx_shift <= {rx_shift[30:0], miso_sel};
            // Full word including this sample
            if (&rx_bit_cnt) begin
                rx_wr_data <= {rx_shift[30:0], miso_sel};
            end
        end
    end

endmodule

// ==== logic/mspi_params.svh ====
// SPI master sizing
// Buffer depth, buffer address width and number of slave selects

`ifndef MSPI_PARAMS_SVH
`define MSPI_PARAMS_SVH

// Words held by each of the transmit and receive buffers
`define MSPI_BUF_SIZE 256

// Width of a word index into either buffer
`define MSPI_BUF_AW 8

// Active-low slave select lines
// The command carries a 2-bit chip select so this stays at 4
`define MSPI_SS_WIDTH 4

`endif

// ==== logic/mspi_pkg.sv ====
// SPI master shared types
// Data word, buffer index and the enums for the start handshake and APB decode

`include "mspi_params.svh"

package mspi_pkg;

    // Buffer data, APB data and the command word
    typedef logic [31:0] word_t;

    // Word index into a buffer
    typedef logic [`MSPI_BUF_AW-1:0] buf_addr_t;

    // Four-phase start handshake, pclk side
    typedef enum logic [1:0] {
        CDC_ZERO,
        CDC_WAIT_ONE,
        CDC_ONE,
        CDC_WAIT_ZERO
    } cdc_state_e;

    // Decoded APB target
    typedef enum logic [2:0] {
        REGION_CMD,
        REGION_STATUS,
        REGION_TXBUF,
        REGION_RXBUF,
        REGION_NONE
    } reg_region_e;

endpackage

// ==== logic/mspi_top.sv ====
// SPI master top level
// APB registers on pclk, engine on sclk, joined by two word buffers

`timescale 1ns/1ps
`include "mspi_params.svh"

module mspi_top (
    input  logic                      sclk,
    input  logic                      rst_n_sclk,
    input  logic                      pclk,
    input  logic                      rst_n_pclk,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [11:0]               paddr,
    input  mspi_pkg::word_t           pwdata,
    output mspi_pkg::word_t           prdata,
    output logic                      pslverr,
    output logic [`MSPI_SS_WIDTH-1:0] ss_n,
    output logic                      mosi,
    input  logic [`MSPI_SS_WIDTH-1:0] miso
);
    import mspi_pkg::*;

    // Transmit buffer, written on pclk
    logic      tx_wr_en;
    buf_addr_t tx_wr_addr;
    word_t     tx_wr_data;
    buf_addr_t tx_rd_addr;
    word_t     tx_rd_data;
    // Receive buffer, written on sclk
    logic      rx_wr_en;
    buf_addr_t rx_wr_addr;
    word_t     rx_wr_data;
    buf_addr_t rx_rd_addr;
    word_t     rx_rd_data;
    // Crossing between the domains
    word_t     cmd_word;
    logic      cdc_req;
    logic      ack_sclk;
    logic      start_level;
    logic      spi_active;

    mspi_apb_regs u_regs (
        .pclk        (pclk),
        .rst_n_pclk  (rst_n_pclk),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pslverr     (pslverr),
        .tx_wr_en    (tx_wr_en),
        .tx_wr_addr  (tx_wr_addr),
        .tx_wr_data  (tx_wr_data),
        .rx_rd_addr  (rx_rd_addr),
        .rx_rd_data  (rx_rd_data),
        .cmd_word    (cmd_word),
        .cdc_req     (cdc_req),
        .start_level (start_level),
        .ack_sclk    (ack_sclk),
        .active_sclk (spi_active)
    );

    mspi_buf u_tx_buf (
        .wr_clk  (pclk),
        .wr_en   (tx_wr_en),
        .wr_addr (tx_wr_addr),
        .wr_data (tx_wr_data),
        .rd_addr (tx_rd_addr),
        .rd_data (tx_rd_data)
    );

    mspi_buf u_rx_buf (
        .wr_clk  (sclk),
        .wr_en   (rx_wr_en),
        .wr_addr (rx_wr_addr),
        .wr_data (rx_wr_data),
        .rd_addr (rx_rd_addr),
        .rd_data (rx_rd_data)
    );

    mspi_intf u_intf (
        .sclk        (sclk),
        .rst_n_sclk  (rst_n_sclk),
        .cmd_word    (cmd_word),
        .cdc_req     (cdc_req),
        .start_level (start_level),
        .ack_sclk    (ack_sclk),
        .tx_rd_addr  (tx_rd_addr),
        .tx_rd_data  (tx_rd_data),
        .rx_wr_en    (rx_wr_en),
        .rx_wr_addr  (rx_wr_addr),
        .rx_wr_data  (rx_wr_data),
        .spi_active  (spi_active),
        .ss_n        (ss_n),
        .mosi        (mosi),
        .miso        (miso)
    );

endmodule

// ==== logic/spi_bitsync.sv ====
// Single-bit synchronizer
// Two flops into the destination clock, cleared on reset

`timescale 1ns/1ps

module spi_bitsync (
    input  logic clk,
    input  logic rst_n,
    input  logic data_in,
    output logic data_out
);

    // First stage may go metastable
    logic meta;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta     <= 1'b0;
            data_out <= 1'b0;
        end else begin
            meta     <= data_in;
            data_out <= meta;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the SPI master testbench with Verilator and run it.
# The exit status is that of the simulation.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f vlog.f \
    --top-module mspi_tb \
    -Mdir obj_dir \
    -o mspi_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build exited with status $status"
    exit "$status"
fi

./obj_dir/mspi_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Run exited with status $status"
    exit "$status"
fi

exit 0

// ==== sim/mspi_clkgen.sv ====
// Testbench clock and reset source
// sclk at 20 ns and pclk at 14 ns, both resets held for 4 sclk cycles

`timescale 1ns/1ps

module mspi_clkgen (
    output logic sclk,
    output logic pclk,
    output logic rst_n_sclk,
    output logic rst_n_pclk
);

    // Free-running and unrelated, so the start crossing sees every phase
    initial begin
        sclk = 1'b0;
        forever #10 sclk = ~sclk;
    end

    initial begin
        pclk = 1'b0;
        forever #7 pclk = ~pclk;
    end

    // Release away from the rising edges
    initial begin
        rst_n_sclk = 1'b0;
        rst_n_pclk = 1'b0;
        repeat (4) @(posedge sclk);
        @(negedge sclk);
        rst_n_sclk = 1'b1;
        rst_n_pclk = 1'b1;
    end

endmodule

// ==== sim/mspi_tb.sv ====
// Testbench for the SPI master
// Random transfers through APB, a four-line SPI slave model and
// checks of mosi data, receive buffer contents, handshake and bus errors

`timescale 1ns/1ps
`include "mspi_params.svh"

module mspi_tb;
    import mspi_pkg::*;

    localparam logic [11:0] CMD_ADDR    = 12'h000;
    localparam logic [11:0] STATUS_ADDR = 12'h004;
    localparam logic [11:0] TXBUF_BASE  = 12'h400;
    localparam logic [11:0] RXBUF_BASE  = 12'h800;
    localparam int MAX_WORDS  = 16;
    localparam int POLL_LIMIT = 2000;

    logic sclk;
    logic pclk;
    logic rst_n_sclk;
    logic rst_n_pclk;
    logic psel;
    logic penable;
    logic pwrite;
    logic [11:0] paddr;
    word_t pwdata;
    word_t prdata;
    logic pslverr;
    logic [`MSPI_SS_WIDTH-1:0] ss_n;
    logic mosi;
    logic [`MSPI_SS_WIDTH-1:0] miso;

    integer seed = 32'h0e7d_196e;

    // Slave model state
    word_t line_words [`MSPI_SS_WIDTH][MAX_WORDS];
    word_t tx_words [MAX_WORDS];
    word_t mosi_rec [MAX_WORDS];
    word_t mosi_shift;
    int sample_cnt;
    logic [1:0] cur_cs;
    logic [`MSPI_SS_WIDTH-1:0] sel_mask;

    mspi_clkgen u_clkgen (
        .sclk       (sclk),
        .pclk       (pclk),
        .rst_n_sclk (rst_n_sclk),
        .rst_n_pclk (rst_n_pclk)
    );

    mspi_top dut (
        .sclk       (sclk),
        .rst_n_sclk (rst_n_sclk),
        .pclk       (pclk),
        .rst_n_pclk (rst_n_pclk),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pslverr    (pslverr),
        .ss_n       (ss_n),
        .mosi       (mosi),
        .miso       (miso)
    );

    ////////////////////////////////////////
    // Failure reporting and compares
    ////////////////////////////////////////

    task automatic end_with_failure();
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
            end_with_failure();
        end
    endtask

    ////////////////////////////////////////
    // APB driver
    ////////////////////////////////////////

    // Setup and access on falling pclk, results taken at the rising edge
    task automatic apb_access(input logic wr, input logic [11:0] addr, input word_t wdata,
                              output word_t rdata, output logic err);
        @(negedge pclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge pclk);
        penable = 1'b1;
        @(posedge pclk);
        rdata = prdata;
        err   = pslverr;
        @(negedge pclk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input word_t data, output logic err);
        word_t unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [11:0] addr, output word_t data, output logic err);
        apb_access(1'b0, addr, 32'd0, data, err);
    endtask

    // Poll one status bit until it reaches the wanted value
    task automatic wait_status(input int bit_idx, input logic value, input string what);
        word_t rdata;
        logic  err;
        int    polls;
        polls = 0;
        apb_read(STATUS_ADDR, rdata, err);
        while (rdata[bit_idx] !== value) begin
            if (polls == POLL_LIMIT) begin
                $display("Timed out after %0d status reads waiting for %s", polls, what);
                end_with_failure();
            end else begin
                apb_read(STATUS_ADDR, rdata, err);
                polls++;
            end
        end
    endtask

    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        while (rst_n_pclk !== 1'b1 || rst_n_sclk !== 1'b1) begin
            if (cycles == 50) begin
                $display("Reset was never released");
                end_with_failure();
            end else begin
                @(posedge pclk);
                cycles++;
            end
        end
        repeat (2) @(posedge pclk);
    endtask

    ////////////////////////////////////////
    // SPI slave model
    ////////////////////////////////////////

    // Each line shows the bit at the current sample index, MSB first
    always @(negedge sclk) begin
        if (sample_cnt < 32 * MAX_WORDS) begin
            for (int l = 0; l < `MSPI_SS_WIDTH; l++) begin
                miso[l] = line_words[l][sample_cnt / 32][31 - (sample_cnt % 32)];
            end
        end
    end

    // Sample mosi where the slave would, on rising sclk with select low
    always @(posedge sclk) begin
        if (rst_n_sclk === 1'b1) begin
            if ((ss_n | sel_mask) !== '1) begin
                $display("Select line other than %0d went low, ss_n %b", cur_cs, ss_n);
                end_with_failure();
            end
            if (ss_n[cur_cs] === 1'b0) begin
                if (sample_cnt >= 32 * MAX_WORDS) begin
                    $display("More than %0d words shifted in one transfer", MAX_WORDS);
                    end_with_failure();
                end
                mosi_shift = {mosi_shift[30:0], mosi};
                if (sample_cnt % 32 == 31) begin
                    mosi_rec[sample_cnt / 32] = mosi_shift;
                end
                sample_cnt = sample_cnt + 1;
            end
        end
    end

    ////////////////////////////////////////
    // Test sequences
    ////////////////////////////////////////

    task automatic check_apb_errors();
        word_t rdata;
        word_t val;
        logic  err;
        apb_write(RXBUF_BASE, $random(seed), err);
        check_bit("pslverr on RXBUF write", 1'b1, err);
        apb_read(TXBUF_BASE + 12'h3fc, rdata, err);
        check_bit("pslverr on TXBUF read", 1'b1, err);
        apb_read(12'h008, rdata, err);
        check_bit("pslverr on unmapped read", 1'b1, err);
        apb_write(12'hc00, $random(seed), err);
        check_bit("pslverr on unmapped write", 1'b1, err);
        apb_read(STATUS_ADDR, rdata, err);
        check_bit("pslverr on STATUS read", 1'b0, err);
        apb_read(RXBUF_BASE + 12'h004, rdata, err);
        check_bit("pslverr on RXBUF read", 1'b0, err);
        // Start stays 0 so no handshake begins
        val    = $random(seed);
        val[0] = 1'b0;
        apb_write(CMD_ADDR, val, err);
        check_bit("pslverr on CMD write", 1'b0, err);
        apb_read(CMD_ADDR, rdata, err);
        check_bit("pslverr on CMD read", 1'b0, err);
        check_word("CMD readback", val, rdata);
    endtask

    task automatic run_transfer(input logic second_start);
        word_t      cmd;
        word_t      rdata;
        logic       err;
        logic [1:0] cs;
        logic [7:0] last;
        int         n;
        int         w;
        int         l;
        last = 8'($random(seed) & 32'hf);
        cs   = 2'($random(seed));
        n    = int'(last) + 1;
        // Fresh data on every miso line, only the selected one is expected back
        for (w = 0; w < MAX_WORDS; w++) begin
            for (l = 0; l < `MSPI_SS_WIDTH; l++) begin
                line_words[l][w] = $random(seed);
            end
        end
        sel_mask     = '0;
        sel_mask[cs] = 1'b1;
        cur_cs       = cs;
        sample_cnt   = 0;
        mosi_shift   = '0;
        for (w = 0; w < n; w++) begin
            tx_words[w] = $random(seed);
            apb_write(TXBUF_BASE + 12'(4 * w), tx_words[w], err);
            check_bit("pslverr on TXBUF write", 1'b0, err);
        end
        cmd = {cs, 20'd0, last, 2'b01};
        apb_write(CMD_ADDR, cmd, err);
        check_bit("pslverr on CMD start", 1'b0, err);
        // Request still crossing both synchronizers
        apb_read(STATUS_ADDR, rdata, err);
        check_bit("hs_busy after start 1", 1'b1, rdata[0]);
        // Another start while busy must not replace the command
        if (second_start) begin
            apb_write(CMD_ADDR, {~cs, 20'd0, ~last, 2'b01}, err);
            apb_read(CMD_ADDR, rdata, err);
            check_word("CMD held during transfer", cmd, rdata);
        end
        wait_status(1, 1'b1, "done");
        check_word("bits seen on mosi", word_t'(32 * n), word_t'(sample_cnt));
        for (w = 0; w < n; w++) begin
            check_word($sformatf("mosi word %0d", w), tx_words[w], mosi_rec[w]);
        end
        for (w = 0; w < n; w++) begin
            apb_read(RXBUF_BASE + 12'(4 * w), rdata, err);
            check_bit("pslverr on RXBUF read", 1'b0, err);
            check_word($sformatf("RXBUF word %0d", w), line_words[cs][w], rdata);
        end
        // Return the handshake to zero
        cmd[0] = 1'b0;
        apb_write(CMD_ADDR, cmd, err);
        apb_read(STATUS_ADDR, rdata, err);
        check_bit("done after start 0", 1'b0, rdata[1]);
        check_bit("hs_busy after start 0", 1'b1, rdata[0]);
        wait_status(0, 1'b0, "hs_busy to fall");
        apb_read(CMD_ADDR, rdata, err);
        check_word("CMD readback after start 0", cmd, rdata);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin : stimulus
        word_t rdata;
        logic  err;
        int    i;
        int    l;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        miso       = '0;
        sample_cnt = 0;
        mosi_shift = '0;
        cur_cs     = 2'd0;
        sel_mask   = 4'b0001;
        for (i = 0; i < MAX_WORDS; i++) begin
            for (l = 0; l < `MSPI_SS_WIDTH; l++) begin
                line_words[l][i] = '0;
            end
        end
        wait_for_reset();

        // Idle outputs after reset
        check_bit("mosi after reset", 1'b0, mosi);
        check_bit("pslverr after reset", 1'b0, pslverr);
        for (i = 0; i < `MSPI_SS_WIDTH; i++) begin
            check_bit($sformatf("ss_n[%0d] after reset", i), 1'b1, ss_n[i]);
        end
        apb_read(STATUS_ADDR, rdata, err);
        check_word("status after reset", '0, rdata);

        check_apb_errors();

        run_transfer(1'b0);
        run_transfer(1'b1);
        // Back to back
        for (i = 0; i < 12; i++) begin
            run_transfer(1'b0);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/mspi_pkg.sv
logic/spi_bitsync.sv
logic/mspi_buf.sv
logic/mspi_apb_regs.sv
logic/mspi_intf.sv
logic/mspi_top.sv
sim/mspi_clkgen.sv
sim/mspi_tb.sv
